// File: Makefile
VERILATOR ?= verilator
TOP       ?= logger_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+hw
hw/logger_pkg.sv
hw/console_fsm.sv
hw/adc_timer.sv
hw/packet_descriptor.sv
hw/packet_sender.sv
hw/logger_top.sv
testbench/logger_props.sv
testbench/logger_tb.sv

// File: hw/adc_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "logger_settings.svh"

module adc_timer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire logger_pkg::adc_op_e adc_op,
    output logic                adc_done
);

    localparam int CNT_W = 8;

    logger_pkg::adc_op_e prev_op;
    logic [CNT_W-1:0]    latency;
    logic [CNT_W-1:0]    count;
    logic                armed;
    logic                load;

    always_comb begin
        case (adc_op)
            logger_pkg::OP_INIT: latency = CNT_W'(`LOG_LAT_INIT);
            logger_pkg::OP_TYPE: latency = CNT_W'(`LOG_LAT_TYPE);
            logger_pkg::OP_CONF: latency = CNT_W'(`LOG_LAT_CONF);
            logger_pkg::OP_CONV: latency = CNT_W'(`LOG_LAT_CONV);
            logger_pkg::OP_TRAN: latency = CNT_W'(`LOG_LAT_TRAN);
            default:             latency = '0;
        endcase
    end

    // a new request is a step away from NONE, or the switch to a transfer
    assign load = (adc_op != logger_pkg::OP_NONE) &&
                  ((prev_op == logger_pkg::OP_NONE) ||
                   (adc_op == logger_pkg::OP_TRAN && prev_op != logger_pkg::OP_TRAN));

    assign adc_done = armed && (count == '0) && (adc_op != logger_pkg::OP_NONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_op <= logger_pkg::OP_NONE;
            armed   <= 1'b0;
            count   <= '0;
        end else begin
            prev_op <= adc_op;
            if (adc_op == logger_pkg::OP_NONE) begin
                armed <= 1'b0;
            end else if (load) begin
                armed <= 1'b1;
                count <= latency - CNT_W'(1);
            end else if (adc_done) begin
                armed <= 1'b0;
            end else if (armed) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/console_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module console_fsm (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  host_read,
    input  wire logger_pkg::btype_e host_btype,
    input  wire                  adc_done,
    input  wire                  send_done,
    output logic                 read_ack,
    output logger_pkg::adc_op_e  adc_op,
    output logic                 take,
    output logger_pkg::adc_op_e  take_op,
    output logic                 send,
    output logic                 clear
);

    // bit positions of the one-hot state vector
    localparam int MAIN_IDLE  = 0;
    localparam int MAIN_WAIT  = 1;
    localparam int MAIN_TAKE  = 2;
    localparam int LINK_IDLE  = 3;
    localparam int LINK_WORK  = 4;
    localparam int LINK_TAKE  = 5;
    localparam int LINK_SEND  = 6;
    localparam int LINK_DONE  = 7;
    localparam int TYPE_IDLE  = 8;
    localparam int TYPE_WORK  = 9;
    localparam int TYPE_TAKE  = 10;
    localparam int TYPE_SEND  = 11;
    localparam int TYPE_DONE  = 12;
    localparam int CONF_IDLE  = 13;
    localparam int CONF_WORK  = 14;
    localparam int CONF_TAKE  = 15;
    localparam int CONF_SEND  = 16;
    localparam int CONF_DONE  = 17;
    localparam int CONV_IDLE  = 18;
    localparam int CONV_WORK  = 19;
    localparam int CONV_TAKE  = 20;
    localparam int CONV_SEND  = 21;
    localparam int CONV_DONE  = 22;
    localparam int NUM_STATES = 23;

    logic [NUM_STATES-1:0] state;
    logic [NUM_STATES-1:0] next_state;
    logic                  tran_seen;
    logic                  sent_seen;
    logic                  conv_fin;

    // both the RAM transfer and the host send must finish, in either order
    assign conv_fin = (tran_seen | adc_done) & (sent_seen | send_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= NUM_STATES'(1) << MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = '0;
        case (1'b1)
            state[MAIN_IDLE]: next_state[LINK_IDLE] = 1'b1;
            state[MAIN_WAIT]: next_state[host_read ? MAIN_TAKE : MAIN_WAIT] = 1'b1;
            state[MAIN_TAKE]: begin
                case (host_btype)
                    logger_pkg::BT_DIDX:   next_state[TYPE_IDLE] = 1'b1;
                    logger_pkg::BT_DPARAM: next_state[CONF_IDLE] = 1'b1;
                    logger_pkg::BT_DDIDX:  next_state[CONV_IDLE] = 1'b1;
                    // unknown commands are dropped without an ack
                    default:               next_state[MAIN_WAIT] = 1'b1;
                endcase
            end
            state[LINK_IDLE]: next_state[LINK_WORK] = 1'b1;
            state[LINK_WORK]: next_state[adc_done ? LINK_TAKE : LINK_WORK] = 1'b1;
            state[LINK_TAKE]: next_state[LINK_SEND] = 1'b1;
            state[LINK_SEND]: next_state[send_done ? LINK_DONE : LINK_SEND] = 1'b1;
            state[LINK_DONE]: next_state[MAIN_WAIT] = 1'b1;
            state[TYPE_IDLE]: next_state[host_read ? TYPE_IDLE : TYPE_WORK] = 1'b1;
            state[TYPE_WORK]: next_state[adc_done ? TYPE_TAKE : TYPE_WORK] = 1'b1;
            state[TYPE_TAKE]: next_state[TYPE_SEND] = 1'b1;
            state[TYPE_SEND]: next_state[send_done ? TYPE_DONE : TYPE_SEND] = 1'b1;
            state[TYPE_DONE]: next_state[MAIN_WAIT] = 1'b1;
            state[CONF_IDLE]: next_state[host_read ? CONF_IDLE : CONF_WORK] = 1'b1;
            state[CONF_WORK]: next_state[adc_done ? CONF_TAKE : CONF_WORK] = 1'b1;
            state[CONF_TAKE]: next_state[CONF_SEND] = 1'b1;
            state[CONF_SEND]: next_state[send_done ? CONF_DONE : CONF_SEND] = 1'b1;
            state[CONF_DONE]: next_state[MAIN_WAIT] = 1'b1;
            state[CONV_IDLE]: next_state[host_read ? CONV_IDLE : CONV_WORK] = 1'b1;
            state[CONV_WORK]: next_state[adc_done ? CONV_TAKE : CONV_WORK] = 1'b1;
            state[CONV_TAKE]: next_state[CONV_SEND] = 1'b1;
            state[CONV_SEND]: next_state[conv_fin ? CONV_DONE : CONV_SEND] = 1'b1;
            state[CONV_DONE]: next_state[MAIN_WAIT] = 1'b1;
            default:          next_state[MAIN_IDLE] = 1'b1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tran_seen <= 1'b0;
            sent_seen <= 1'b0;
        end else if (state[CONV_SEND] && !conv_fin) begin
            if (adc_done) tran_seen <= 1'b1;
            if (send_done) sent_seen <= 1'b1;
        end else begin
            tran_seen <= 1'b0;
            sent_seen <= 1'b0;
        end
    end

    always_comb begin
        adc_op = logger_pkg::OP_NONE;
        case (1'b1)
            state[LINK_WORK]: adc_op = logger_pkg::OP_INIT;
            state[TYPE_WORK]: adc_op = logger_pkg::OP_TYPE;
            state[CONF_WORK]: adc_op = logger_pkg::OP_CONF;
            state[CONV_WORK]: adc_op = logger_pkg::OP_CONV;
            state[CONV_SEND]: adc_op = logger_pkg::OP_TRAN;
            default:          adc_op = logger_pkg::OP_NONE;
        endcase
    end

    always_comb begin
        take_op = logger_pkg::OP_NONE;
        case (1'b1)
            state[LINK_TAKE]: take_op = logger_pkg::OP_INIT;
            state[TYPE_TAKE]: take_op = logger_pkg::OP_TYPE;
            state[CONF_TAKE]: take_op = logger_pkg::OP_CONF;
            state[CONV_TAKE]: take_op = logger_pkg::OP_CONV;
            default:          take_op = logger_pkg::OP_NONE;
        endcase
    end

    assign take     = state[LINK_TAKE] | state[TYPE_TAKE] | state[CONF_TAKE] | state[CONV_TAKE];
    assign send     = state[LINK_SEND] | state[TYPE_SEND] | state[CONF_SEND] | state[CONV_SEND];
    assign read_ack = state[TYPE_IDLE] | state[CONF_IDLE] | state[CONV_IDLE];
    assign clear    = state[MAIN_IDLE] | state[MAIN_WAIT];

endmodule

`default_nettype wire

// File: hw/logger_pkg.sv
`default_nettype none

package logger_pkg;

    // packet type field as seen on the host link
    typedef enum logic [3:0] {
        BT_INIT   = 4'd0,
        BT_DIDX   = 4'd5,
        BT_DPARAM = 4'd6,
        BT_DDIDX  = 4'd7,
        BT_DLINK  = 4'd8,
        BT_DTYPE  = 4'd9,
        BT_DTEMP  = 4'd10,
        BT_DATA0  = 4'd13,
        BT_DATA1  = 4'd14
    } btype_e;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_INIT,
        OP_TYPE,
        OP_CONF,
        OP_CONV,
        OP_TRAN
    } adc_op_e;

    typedef struct packed {
        btype_e      btype;
        logic [11:0] addr;
        logic [11:0] dlen;
    } pkt_desc_t;

    typedef struct packed {
        logic        valid;
        btype_e      btype;
        logic [11:0] addr;
        logic        last;
    } tx_word_t;

    // fixed RAM locations of the control packets
    localparam logic [11:0] RAM_ADDR_INIT  = 12'hFE0;
    localparam logic [11:0] RAM_ADDR_DLINK = 12'hFCC;
    localparam logic [11:0] RAM_ADDR_DTYPE = 12'hFC0;
    localparam logic [11:0] RAM_ADDR_DTEMP = 12'hFC4;

endpackage

`default_nettype wire

// File: hw/logger_settings.svh
`ifndef LOGGER_SETTINGS_SVH
`define LOGGER_SETTINGS_SVH

// ADC operation latencies in clock cycles
`define LOG_LAT_INIT 20
`define LOG_LAT_TYPE 8
`define LOG_LAT_CONF 12
`define LOG_LAT_CONV 30

// transfer of one conversion result into RAM
`define LOG_LAT_TRAN 6

// conversion results rotate through this many RAM frames
`define LOG_NUM_FRAMES 6

// packet lengths in RAM words
`define LOG_CTRL_DLEN 'h002
`define LOG_DATA_DLEN 'h202

// frame n starts at n times the stride
`define LOG_FRAME_STRIDE 'h240

`endif

// File: hw/logger_top.sv
`timescale 1ns/1ps
`default_nettype none

module logger_top (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   host_read,
    input  wire logger_pkg::btype_e host_btype,
    output logic                  read_ack,
    output logger_pkg::tx_word_t  tx,
    output logger_pkg::pkt_desc_t desc
);

    logger_pkg::adc_op_e adc_op;
    logger_pkg::adc_op_e take_op;
    logic                adc_done;
    logic                take;
    logic                send;
    logic                send_done;
    logic                clear;

    console_fsm fsm_i (
        .clk        (clk),
        .rst        (rst),
        .host_read  (host_read),
        .host_btype (host_btype),
        .adc_done   (adc_done),
        .send_done  (send_done),
        .read_ack   (read_ack),
        .adc_op     (adc_op),
        .take       (take),
        .take_op    (take_op),
        .send       (send),
        .clear      (clear)
    );

    adc_timer timer_i (
        .clk      (clk),
        .rst      (rst),
        .adc_op   (adc_op),
        .adc_done (adc_done)
    );

    packet_descriptor desc_i (
        .clk     (clk),
        .rst     (rst),
        .take    (take),
        .take_op (take_op),
        .clear   (clear),
        .desc    (desc)
    );

    packet_sender sender_i (
        .clk       (clk),
        .rst       (rst),
        .send      (send),
        .desc      (desc),
        .tx        (tx),
        .send_done (send_done)
    );

endmodule

`default_nettype wire

// File: hw/packet_descriptor.sv
`timescale 1ns/1ps
`default_nettype none

`include "logger_settings.svh"

module packet_descriptor (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   take,
    input  wire logger_pkg::adc_op_e take_op,
    input  wire                   clear,
    output logger_pkg::pkt_desc_t desc
);

    localparam int          NUM_FRAMES   = `LOG_NUM_FRAMES;
    localparam int          FRAME_W      = $clog2(NUM_FRAMES);
    localparam logic [11:0] CTRL_DLEN    = 12'(`LOG_CTRL_DLEN);
    localparam logic [11:0] DATA_DLEN    = 12'(`LOG_DATA_DLEN);
    localparam logic [11:0] FRAME_STRIDE = 12'(`LOG_FRAME_STRIDE);

    logic [FRAME_W-1:0]    frame;
    logic [11:0]           frame_base;
    logger_pkg::pkt_desc_t next_desc;
    logger_pkg::pkt_desc_t idle_desc;

    assign frame_base = 12'(frame) * FRAME_STRIDE;

    assign idle_desc = '{btype: logger_pkg::BT_INIT, addr: logger_pkg::RAM_ADDR_INIT,
                         dlen: 12'h000};

    always_comb begin
        next_desc = desc;
        case (take_op)
            logger_pkg::OP_INIT: begin
                next_desc = '{logger_pkg::BT_DLINK, logger_pkg::RAM_ADDR_DLINK, CTRL_DLEN};
            end
            logger_pkg::OP_TYPE: begin
                next_desc = '{logger_pkg::BT_DTYPE, logger_pkg::RAM_ADDR_DTYPE, CTRL_DLEN};
            end
            logger_pkg::OP_CONF: begin
                next_desc = '{logger_pkg::BT_DTEMP, logger_pkg::RAM_ADDR_DTEMP, CTRL_DLEN};
            end
            logger_pkg::OP_CONV: begin
                // odd frames go out as DATA1 so the host can spot a lost packet
                next_desc.btype = frame[0] ? logger_pkg::BT_DATA1 : logger_pkg::BT_DATA0;
                next_desc.addr  = frame_base;
                next_desc.dlen  = DATA_DLEN;
            end
            default: next_desc = desc;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame <= '0;
        end else if (take && take_op == logger_pkg::OP_CONV) begin
            frame <= (frame == FRAME_W'(NUM_FRAMES - 1)) ? '0 : frame + FRAME_W'(1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            desc <= idle_desc;
        end else if (clear) begin
            desc <= idle_desc;
        end else if (take) begin
            desc <= next_desc;
        end
    end

endmodule

`default_nettype wire

// File: hw/packet_sender.sv
`timescale 1ns/1ps
`default_nettype none

module packet_sender (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   send,
    input  wire logger_pkg::pkt_desc_t desc,
    output logger_pkg::tx_word_t  tx,
    output logic                  send_done
);

    logic               send_q;
    logic               start;
    logic               busy;
    logic               done_q;
    logger_pkg::btype_e btype_q;
    logic [11:0]        addr_q;
    logic [11:0]        left_q;

    assign start = send && !send_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            send_q <= 1'b0;
            busy   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            send_q <= send;
            done_q <= 1'b0;
            if (start) begin
                // an empty packet completes at once
                busy   <= (desc.dlen != 12'h000);
                done_q <= (desc.dlen == 12'h000);
            end else if (busy && left_q == 12'h000) begin
                busy   <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // left_q counts the words still to go after the current one
    always_ff @(posedge clk) begin
        if (start) begin
            btype_q <= desc.btype;
            addr_q  <= desc.addr;
            left_q  <= desc.dlen - 12'h001;
        end else if (busy) begin
            addr_q <= addr_q + 12'h001;
            left_q <= left_q - 12'h001;
        end
    end

    always_comb begin
        tx.valid = busy;
        tx.btype = btype_q;
        tx.addr  = addr_q;
        tx.last  = busy && (left_q == 12'h000);
    end

    assign send_done = done_q;

endmodule

`default_nettype wire

// File: testbench/logger_props.sv
`timescale 1ns/1ps
`default_nettype none

module logger_props (
    input wire                      clk,
    input wire                      rst,
    input wire                      take,
    input wire                      send,
    input wire                      read_ack,
    input wire logger_pkg::adc_op_e adc_op
);

    logic adc_busy;

    // the WORK states run these ops while the transfer op belongs to a send
    assign adc_busy = (adc_op == logger_pkg::OP_INIT) || (adc_op == logger_pkg::OP_TYPE) ||
                      (adc_op == logger_pkg::OP_CONF) || (adc_op == logger_pkg::OP_CONV);

    take_one_cycle: assert property (@(posedge clk) disable iff (rst) take |=> !take)
        else $error("take stayed high for more than one cycle");

    send_after_work: assert property (@(posedge clk) disable iff (rst) $rose(send) |-> !adc_busy)
        else $error("send rose while an ADC operation was still running");

    ack_low_in_send: assert property (@(posedge clk) disable iff (rst) send |-> !read_ack)
        else $error("read_ack high while a packet is being sent");

endmodule

bind console_fsm logger_props props_i (
    .clk      (clk),
    .rst      (rst),
    .take     (take),
    .send     (send),
    .read_ack (read_ack),
    .adc_op   (adc_op)
);

`default_nettype wire

// File: testbench/logger_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "logger_settings.svh"

module logger_tb;

    localparam int NUM_CMDS       = 40;
    localparam int ACK_WAIT       = 6;
    localparam int SETTLE_CYCLES  = 4;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * (`LOG_NUM_FRAMES * `LOG_DATA_DLEN + 200);
    localparam logic [11:0] CTRL_DLEN = 12'(`LOG_CTRL_DLEN);
    localparam logic [11:0] DATA_DLEN = 12'(`LOG_DATA_DLEN);

    // descriptor held while no packet is being prepared
    localparam logger_pkg::pkt_desc_t IDLE_DESC = '{btype: logger_pkg::BT_INIT,
                                                    addr: logger_pkg::RAM_ADDR_INIT,
                                                    dlen: 12'h000};

    logic                  clk;
    logic                  rst;
    logic                  host_read;
    logger_pkg::btype_e    host_btype;
    logic                  read_ack;
    logger_pkg::tx_word_t  tx;
    logger_pkg::pkt_desc_t desc;

    integer seed;
    int     frame;
    int     cycle_count   = 0;
    int     expected_pkts = 0;
    int     pkts_done     = 0;
    logic   fail_reported = 1'b0;
    logic   run_passed    = 1'b0;

    // reference model output with one entry per packet still to come
    logger_pkg::pkt_desc_t exp_q[$];
    string                 name_q[$];

    logic                  in_pkt = 1'b0;
    int                    idx    = 0;
    logger_pkg::pkt_desc_t cur;
    string                 cur_name;
    logic [11:0]           exp_addr;
    logic                  exp_last;

    logger_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .host_read  (host_read),
        .host_btype (host_btype),
        .read_ack   (read_ack),
        .tx         (tx),
        .desc       (desc)
    );

    always #50 clk = ~clk;

    task automatic print_fail();
        $display("Done: errors found");
    endtask

    task automatic stop_with_error(input string what);
        fail_reported = 1'b1;
        $display("%s", what);
        print_fail();
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_mismatch(input string test, input int expected, input int actual);
        stop_with_error($sformatf("mismatch in %s: expected 0x%0h, actual 0x%0h",
                                  test, expected, actual));
    endtask

    task automatic expect_packet(input logger_pkg::btype_e bt, input logic [11:0] addr,
                                 input logic [11:0] dlen, input string name);
        logger_pkg::pkt_desc_t pkt;
        pkt.btype = bt;
        pkt.addr  = addr;
        pkt.dlen  = dlen;
        exp_q.push_back(pkt);
        name_q.push_back(name);
        expected_pkts = expected_pkts + 1;
    endtask

    // frames rotate through RAM and the type toggles with the frame number
    task automatic expect_conversion(input string name);
        logger_pkg::btype_e bt;
        bt = (frame % 2 == 1) ? logger_pkg::BT_DATA1 : logger_pkg::BT_DATA0;
        expect_packet(bt, 12'(frame * `LOG_FRAME_STRIDE), DATA_DLEN, name);
        frame = (frame + 1) % `LOG_NUM_FRAMES;
    endtask

    function automatic logic [3:0] pick_command();
        int r;
        int u;
        r = {$random(seed)} % 8;
        if (r < 7) begin
            return 4'(5 + r % 3);
        end
        // unknown types skip the three real commands
        u = {$random(seed)} % 13;
        if (u >= 5) begin
            u = u + 3;
        end
        return 4'(u);
    endfunction

    task automatic wait_packets(input int target);
        while (pkts_done < target) begin
            @(negedge clk);
        end
    endtask

    task automatic run_command(input int n);
        logic [3:0] code;
        logic       known;
        logic       acked;
        string      name;
        code  = pick_command();
        known = (code >= 4'd5) && (code <= 4'd7);
        case (code)
            4'd5:    name = $sformatf("index_%0d", n);
            4'd6:    name = $sformatf("parameter_%0d", n);
            4'd7:    name = $sformatf("conversion_%0d", n);
            default: name = $sformatf("unknown_%0d", n);
        endcase
        host_btype = logger_pkg::btype_e'(code);
        host_read  = 1'b1;
        acked      = 1'b0;
        for (int k = 0; k < ACK_WAIT && !acked; k++) begin
            @(negedge clk);
            acked = read_ack;
        end
        assert (acked == known)
            else fail_mismatch({name, " read_ack"}, int'(known), int'(acked));
        host_read = 1'b0;
        case (code)
            4'd5: begin
                expect_packet(logger_pkg::BT_DTYPE, logger_pkg::RAM_ADDR_DTYPE, CTRL_DLEN, name);
            end
            4'd6: begin
                expect_packet(logger_pkg::BT_DTEMP, logger_pkg::RAM_ADDR_DTEMP, CTRL_DLEN, name);
            end
            4'd7: expect_conversion(name);
            default: begin
                // the FSM drops the command and goes back to waiting
                for (int k = 0; k < SETTLE_CYCLES; k++) begin
                    @(negedge clk);
                    assert (!read_ack)
                        else stop_with_error({name, ": read_ack went high for an unknown type"});
                end
            end
        endcase
        wait_packets(expected_pkts);
    endtask

    // tx changes after the rising edge, so words are checked on the falling edge
    always @(negedge clk) begin
        if (!rst && tx.valid) begin
            if (!in_pkt) begin
                assert (exp_q.size() > 0)
                    else stop_with_error("tx word seen while no packet was expected");
                cur      = exp_q.pop_front();
                cur_name = name_q.pop_front();
                idx      = 0;
                in_pkt   = 1'b1;
            end
            exp_addr = cur.addr + 12'(idx);
            exp_last = (idx == int'(cur.dlen) - 1);
            assert (desc == cur)
                else fail_mismatch({cur_name, " desc"}, int'(cur), int'(desc));
            assert (tx.btype == cur.btype)
                else fail_mismatch({cur_name, " btype"}, int'(cur.btype), int'(tx.btype));
            assert (tx.addr == exp_addr)
                else fail_mismatch({cur_name, " addr"}, int'(exp_addr), int'(tx.addr));
            assert (tx.last == exp_last)
                else fail_mismatch({cur_name, " last"}, int'(exp_last), int'(tx.last));
            idx = idx + 1;
            if (exp_last) begin
                in_pkt    = 1'b0;
                pkts_done <= pkts_done + 1;
            end
        end else if (!rst) begin
            assert (!in_pkt)
                else stop_with_error({cur_name, ": tx valid dropped before the last word"});
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout: the run did not finish within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    initial begin
        seed       = 32'h839e;
        clk        = 1'b0;
        rst        = 1'b1;
        host_read  = 1'b0;
        host_btype = logger_pkg::BT_INIT;
        frame      = 0;
        // the link packet goes out on its own after reset
        expect_packet(logger_pkg::BT_DLINK, logger_pkg::RAM_ADDR_DLINK, CTRL_DLEN,
                      "link_after_reset");
        repeat (16) @(negedge clk);
        assert (desc == IDLE_DESC)
            else fail_mismatch("reset_desc", int'(IDLE_DESC), int'(desc));
        assert (!read_ack && !tx.valid)
            else stop_with_error("read_ack or tx valid was high during reset");
        rst = 1'b0;
        wait_packets(1);
        for (int n = 0; n < NUM_CMDS; n++) begin
            run_command(n);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);
        assert (desc == IDLE_DESC)
            else fail_mismatch("idle_desc", int'(IDLE_DESC), int'(desc));
        run_passed = 1'b1;
        $display("Done: no errors");
        $finish;
    end

    final begin
        if (!run_passed && !fail_reported) begin
            print_fail();
        end
    end

endmodule

`default_nettype wire
